// File: hdl/boardPkg.sv
`default_nettype none

package boardPkg;

	typedef logic [7:0] byteT;
	typedef logic [15:0] addrT;

	typedef enum logic [1:0] {
		romRegion,
		vramRegion,
		wramRegion,
		noRegion
	} regionT;

	// ##################################################
	// CPU memory map.
	// ##################################################
	localparam addrT romLowLimit = 16'h8000;
	localparam addrT romHighBase = 16'hE000;

	// Windows are 4 KiB wide and compared on bits 15 to 12.
	localparam addrT vramBase = 16'h8000;
	localparam addrT wramBase = 16'hC000;

	// Set selects the background half of video RAM.
	localparam int bgSelectBit = 11;

	localparam addrT irqVector = 16'h0038;

	localparam int spriteBytes = 2048;
	localparam int bgWords = 1024;

endpackage

`default_nettype wire

// File: hdl/dualPortRam.sv
`default_nettype none

module dualPortRam #(
	parameter int depth = boardPkg::spriteBytes
) (
	input  logic CPUCL,
	input  logic [10:0] aAddr,
	input  logic aWr,
	input  boardPkg::byteT aWrData,
	output boardPkg::byteT aRdData,
	input  logic [10:0] bAddr,
	output boardPkg::byteT bRdData
);
	import boardPkg::*;

	localparam int addrBits = $clog2(depth);

	byteT mem [depth];

	// Port a returns the old byte when it writes and reads the same location.
	always_ff @(posedge CPUCL) begin
		if (aWr) begin
			mem[aAddr[addrBits-1:0]] <= aWrData;
		end
		aRdData <= mem[aAddr[addrBits-1:0]];
		bRdData <= mem[bAddr[addrBits-1:0]];
	end

endmodule

`default_nettype wire

// File: hdl/workRam.sv
`default_nettype none

module workRam (
	input  logic CPUCL,
	input  logic rstN,
	input  boardPkg::addrT cpuAddr,
	input  boardPkg::byteT cpuWrData,
	input  logic cpuWr,
	output boardPkg::byteT rdData
);
	import boardPkg::*;

	localparam int ramBytes = 2048;

	logic inWindow;
	logic [10:0] ramAddr;
	byteT mem [ramBytes];

	// Only 11 address bits reach the RAM, so the 2 KiB repeats across C000-CFFF.
	assign inWindow = cpuAddr[15:12] == wramBase[15:12];
	assign ramAddr = cpuAddr[10:0];

	always_ff @(posedge CPUCL) begin
		if (cpuWr && inWindow) begin
			mem[ramAddr] <= cpuWrData;
		end
	end

	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			rdData <= '0;
		end else begin
			rdData <= mem[ramAddr];
		end
	end

endmodule

`default_nettype wire

// File: hdl/spriteDma.sv
`default_nettype none

module spriteDma #(
	parameter int vblankLine = 194
) (
	input  logic CPUCL,
	input  logic rstN,
	input  logic vblankStart,
	output logic [10:0] dmaAddr,
	output logic dmaWr,
	output logic dmaBusy
);
	import boardPkg::*;

	typedef enum logic [1:0] {
		idlePh,
		readPh,
		writePh,
		waitPh
	} phaseT;

	phaseT phase;

	// The blank line only has to fit the 9-bit line counter.
	if (vblankLine >= 512) begin : gLineCheck
		$error("vblankLine is out of range for a 9-bit vCount");
	end

	// ##################################################
	// Two cycles per byte: read attribute, write shadow.
	// ##################################################
	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			phase <= idlePh;
			dmaAddr <= '0;
		end else begin
			case (phase)
				idlePh: begin
					dmaAddr <= '0;
					if (vblankStart) begin
						phase <= readPh;
					end
				end
				readPh: phase <= writePh;
				writePh: begin
					if (dmaAddr == 11'(spriteBytes - 1)) begin
						phase <= waitPh;
					end else begin
						dmaAddr <= dmaAddr + 11'd1;
						phase <= readPh;
					end
				end
				default: begin
					// Do not rearm until the start pulse has gone.
					if (!vblankStart) begin
						phase <= idlePh;
					end
				end
			endcase
		end
	end

	assign dmaWr = phase == writePh;
	assign dmaBusy = (phase == readPh) || (phase == writePh);

endmodule

`default_nettype wire

// File: hdl/videoRam.sv
`default_nettype none

module videoRam #(
	parameter int vblankLine = 194
) (
	input  logic CPUCL,
	input  logic rstN,
	input  boardPkg::addrT cpuAddr,
	input  boardPkg::byteT cpuWrData,
	input  logic cpuWr,
	output boardPkg::byteT rdData,
	input  logic vblankStart,
	input  logic [9:0] bgAddr,
	output logic [15:0] bgData,
	input  logic [10:0] spriteAddr,
	output boardPkg::byteT spriteData,
	output logic dmaBusy
);
	import boardPkg::*;

	logic inWindow;
	logic bgSel;
	logic bgWrEven;
	logic bgWrOdd;
	logic spWr;
	logic bgSelQ;
	logic oddQ;
	logic [10:0] bankAddr;
	logic [10:0] dmaAddr;
	logic dmaWr;
	byteT evenRd;
	byteT oddRd;
	byteT spRd;
	byteT evenVid;
	byteT oddVid;
	byteT dmaData;

	assign inWindow = cpuAddr[15:12] == vramBase[15:12];
	assign bgSel = cpuAddr[bgSelectBit];
	assign bankAddr = {1'b0, cpuAddr[10:1]};

	// Bit 0 picks the byte bank, so one background word is two neighbouring bytes.
	assign bgWrEven = cpuWr && inWindow && bgSel && !cpuAddr[0];
	assign bgWrOdd = cpuWr && inWindow && bgSel && cpuAddr[0];
	assign spWr = cpuWr && inWindow && !bgSel;

	// ##################################################
	// Background tilemap.
	// ##################################################
	dualPortRam #(.depth(bgWords)) bgEven_i (
		.CPUCL(CPUCL), .aAddr(bankAddr), .aWr(bgWrEven), .aWrData(cpuWrData),
		.aRdData(evenRd), .bAddr({1'b0, bgAddr}), .bRdData(evenVid)
	);

	dualPortRam #(.depth(bgWords)) bgOdd_i (
		.CPUCL(CPUCL), .aAddr(bankAddr), .aWr(bgWrOdd), .aWrData(cpuWrData),
		.aRdData(oddRd), .bAddr({1'b0, bgAddr}), .bRdData(oddVid)
	);

	assign bgData = {oddVid, evenVid};

	// ##################################################
	// Sprite attributes and their shadow copy.
	// ##################################################
	dualPortRam #(.depth(spriteBytes)) spriteAttr_i (
		.CPUCL(CPUCL), .aAddr(cpuAddr[10:0]), .aWr(spWr), .aWrData(cpuWrData),
		.aRdData(spRd), .bAddr(dmaAddr), .bRdData(dmaData)
	);

	dualPortRam #(.depth(spriteBytes)) spriteShadow_i (
		.CPUCL(CPUCL), .aAddr(dmaAddr), .aWr(dmaWr), .aWrData(dmaData),
		.aRdData(), .bAddr(spriteAddr), .bRdData(spriteData)
	);

	spriteDma #(.vblankLine(vblankLine)) spriteDma_i (
		.CPUCL(CPUCL), .rstN(rstN), .vblankStart(vblankStart),
		.dmaAddr(dmaAddr), .dmaWr(dmaWr), .dmaBusy(dmaBusy)
	);

	// The half and bank are remembered so they line up with the RAM output.
	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			bgSelQ <= 1'b0;
			oddQ <= 1'b0;
		end else begin
			bgSelQ <= bgSel;
			oddQ <= cpuAddr[0];
		end
	end

	assign rdData = bgSelQ ? (oddQ ? oddRd : evenRd) : spRd;

endmodule

`default_nettype wire

// File: hdl/vblankIrq.sv
`default_nettype none

module vblankIrq #(
	parameter int vblankLine = 194
) (
	input  logic CPUCL,
	input  logic rstN,
	input  logic [8:0] vCount,
	input  boardPkg::addrT cpuAddr,
	input  logic cpuRd,
	output logic vblankStart,
	output logic irq
);
	import boardPkg::*;

	logic onLine;
	logic onLineQ;
	logic onLinePrev;
	logic vectorFetch;

	assign onLine = vCount == 9'(vblankLine);
	assign vectorFetch = cpuRd && (cpuAddr == irqVector);

	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			onLineQ <= 1'b0;
			onLinePrev <= 1'b0;
			irq <= 1'b0;
		end else begin
			onLineQ <= onLine;
			onLinePrev <= onLineQ;
			// An acknowledge in the same cycle as a new blank wins.
			if (vectorFetch) begin
				irq <= 1'b0;
			end else if (vblankStart) begin
				irq <= 1'b1;
			end
		end
	end

	assign vblankStart = onLineQ && !onLinePrev;

endmodule

`default_nettype wire

// File: hdl/cpuReadMux.sv
`default_nettype none

module cpuReadMux (
	input  logic CPUCL,
	input  logic rstN,
	input  boardPkg::addrT cpuAddr,
	input  boardPkg::byteT romData,
	input  boardPkg::byteT wramData,
	input  boardPkg::byteT vramData,
	output boardPkg::byteT cpuRdData
);
	import boardPkg::*;

	regionT region;
	regionT regionQ;

	always_comb begin
		if (cpuAddr < romLowLimit || cpuAddr >= romHighBase) begin
			region = romRegion;
		end else if (cpuAddr[15:12] == vramBase[15:12]) begin
			region = vramRegion;
		end else if (cpuAddr[15:12] == wramBase[15:12]) begin
			region = wramRegion;
		end else begin
			region = noRegion;
		end
	end

	// Every source answers one cycle late, so the region is delayed to match.
	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			regionQ <= noRegion;
		end else begin
			regionQ <= region;
		end
	end

	always_comb begin
		case (regionQ)
			romRegion: cpuRdData = romData;
			vramRegion: cpuRdData = vramData;
			wramRegion: cpuRdData = wramData;
			default: cpuRdData = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/memSubsys.sv
`default_nettype none

module memSubsys #(
	parameter int vblankLine = 194
) (
	input  logic CPUCL,
	input  logic rstN,
	input  boardPkg::addrT cpuAddr,
	input  boardPkg::byteT cpuWrData,
	input  logic cpuWr,
	input  logic cpuRd,
	output boardPkg::byteT cpuRdData,
	output boardPkg::addrT romAddr,
	input  boardPkg::byteT romData,
	input  logic [8:0] vCount,
	input  logic [9:0] bgAddr,
	output logic [15:0] bgData,
	input  logic [10:0] spriteAddr,
	output boardPkg::byteT spriteData,
	output logic irq,
	output logic dmaBusy
);
	import boardPkg::*;

	byteT wramData;
	byteT vramData;
	logic vblankStart;

	// The program ROM sits outside and sees the CPU address as is.
	assign romAddr = cpuAddr;

	workRam workRam_i (
		.CPUCL(CPUCL), .rstN(rstN), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuWr(cpuWr), .rdData(wramData)
	);

	videoRam #(.vblankLine(vblankLine)) videoRam_i (
		.CPUCL(CPUCL), .rstN(rstN), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuWr(cpuWr), .rdData(vramData), .vblankStart(vblankStart),
		.bgAddr(bgAddr), .bgData(bgData), .spriteAddr(spriteAddr),
		.spriteData(spriteData), .dmaBusy(dmaBusy)
	);

	vblankIrq #(.vblankLine(vblankLine)) vblankIrq_i (
		.CPUCL(CPUCL), .rstN(rstN), .vCount(vCount), .cpuAddr(cpuAddr),
		.cpuRd(cpuRd), .vblankStart(vblankStart), .irq(irq)
	);

	cpuReadMux cpuReadMux_i (
		.CPUCL(CPUCL), .rstN(rstN), .cpuAddr(cpuAddr), .romData(romData),
		.wramData(wramData), .vramData(vramData), .cpuRdData(cpuRdData)
	);

endmodule

`default_nettype wire

// File: verification/memSubsys_props.sv
`default_nettype none

module memSubsys_props #(
	parameter int vblankLine = 194
) (
	input logic CPUCL,
	input logic rstN,
	input logic [8:0] vCount,
	input logic vblankStart,
	input logic irq,
	input logic dmaBusy,
	input logic dmaWr
);
	timeunit 1ns;
	timeprecision 1ps;
	import boardPkg::*;

	logic [12:0] busyCycles;

	// Counts how long the current DMA run has been busy.
	always_ff @(posedge CPUCL or negedge rstN) begin
		if (!rstN) begin
			busyCycles <= '0;
		end else if (dmaBusy) begin
			busyCycles <= busyCycles + 13'd1;
		end else begin
			busyCycles <= '0;
		end
	end

	resetQuiet: assert property (@(posedge CPUCL) $rose(rstN) |-> !irq && !dmaBusy && !dmaWr)
		else $error("irq or DMA active right after reset");

	// The blank line reaches irq through the registered compare and the start pulse.
	irqCause: assert property (@(posedge CPUCL) disable iff (!rstN)
		$rose(irq) |-> $past(vblankStart) && $past(vCount == 9'(vblankLine), 2))
		else $error("irq rose without the blank line and a vblankStart pulse before it");

	wrInBusy: assert property (@(posedge CPUCL) disable iff (!rstN)
		dmaWr |-> dmaBusy && $past(dmaBusy) && !$past(dmaWr))
		else $error("DMA write strobe outside a busy period or not after a read cycle");

	busyLength: assert property (@(posedge CPUCL) disable iff (!rstN)
		$fell(dmaBusy) |-> busyCycles == 13'(2 * spriteBytes))
		else $error("dmaBusy lasted %0d cycles", busyCycles);

endmodule

bind memSubsys memSubsys_props #(.vblankLine(vblankLine)) props_i (
	.CPUCL(CPUCL), .rstN(rstN), .vCount(vCount), .vblankStart(vblankStart), .irq(irq),
	.dmaBusy(dmaBusy), .dmaWr(videoRam_i.dmaWr)
);

`default_nettype wire

// File: verification/memSubsysTb.sv
`default_nettype none

module memSubsysTb;
	timeunit 1ns;
	timeprecision 1ps;
	import boardPkg::*;

	localparam int vblankLine = 194;
	localparam int irqLatency = 2;
	localparam int irqTimeout = 16;
	localparam int dmaTimeout = 2 * spriteBytes + 64;
	localparam int lineFeed = 10;
	localparam string goldenPath = "verification/memSubsys_golden.txt";

	logic CPUCL = 1'b0;
	logic rstN;
	addrT cpuAddr;
	byteT cpuWrData;
	logic cpuWr;
	logic cpuRd;
	byteT cpuRdData;
	addrT romAddr;
	byteT romData = 8'h00;
	logic [8:0] vCount;
	logic [9:0] bgAddr;
	logic [15:0] bgData;
	logic [10:0] spriteAddr;
	byteT spriteData;
	logic irq;
	logic dmaBusy;

	int errors;
	int checks;
	bit aborted;

	memSubsys #(.vblankLine(vblankLine)) dut_i (
		.CPUCL(CPUCL), .rstN(rstN), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuWr(cpuWr), .cpuRd(cpuRd), .cpuRdData(cpuRdData), .romAddr(romAddr),
		.romData(romData), .vCount(vCount), .bgAddr(bgAddr), .bgData(bgData),
		.spriteAddr(spriteAddr), .spriteData(spriteData), .irq(irq), .dmaBusy(dmaBusy)
	);

	always #4 CPUCL = ~CPUCL;

	// Program ROM answers one cycle after the address.
	always @(posedge CPUCL) begin
		romData <= romAddr[7:0] ^ 8'hA5;
	end

	task automatic reportMismatch(string name, logic [15:0] got, logic [15:0] exp);
		errors++;
		$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic idleBus();
		@(posedge CPUCL);
		cpuWr <= 1'b0;
		cpuRd <= 1'b0;
	endtask

	task automatic writeByte(addrT addr, byteT data);
		@(posedge CPUCL);
		cpuAddr <= addr;
		cpuWrData <= data;
		cpuWr <= 1'b1;
		cpuRd <= 1'b0;
		@(posedge CPUCL);
		cpuWr <= 1'b0;
	endtask

	task automatic readCheck(addrT addr, byteT exp);
		byteT heldData;
		@(posedge CPUCL);
		cpuAddr <= addr;
		cpuRd <= 1'b1;
		cpuWr <= 1'b0;
		@(posedge CPUCL);
		@(negedge CPUCL);
		checks++;
		if (cpuRdData !== exp) begin
			reportMismatch("cpuRdData", {8'h00, cpuRdData}, {8'h00, exp});
		end
		checks++;
		if (romAddr !== addr) begin
			reportMismatch("romAddr", romAddr, addr);
		end
		heldData = cpuRdData;
		// The byte has to stay put while the address is held.
		@(negedge CPUCL);
		checks++;
		if (cpuRdData !== heldData) begin
			reportMismatch("cpuRdData (held)", {8'h00, cpuRdData}, {8'h00, heldData});
		end
		idleBus();
	endtask

	task automatic checkBg(logic [9:0] addr, logic [15:0] exp);
		@(posedge CPUCL);
		bgAddr <= addr;
		@(posedge CPUCL);
		@(negedge CPUCL);
		checks++;
		if (bgData !== exp) begin
			reportMismatch("bgData", bgData, exp);
		end
	endtask

	task automatic checkSprite(logic [10:0] addr, byteT exp);
		@(posedge CPUCL);
		spriteAddr <= addr;
		@(posedge CPUCL);
		@(negedge CPUCL);
		checks++;
		if (spriteData !== exp) begin
			reportMismatch("spriteData", {8'h00, spriteData}, {8'h00, exp});
		end
	endtask

	// ##################################################
	// Vertical blank and interrupt acknowledge.
	// ##################################################
	task automatic runVblank();
		int cycles;
		checks++;
		if (irq !== 1'b0) begin
			errors++;
			$display("irq was already set before the vertical blank at %0t ns", $time);
		end
		@(posedge CPUCL);
		vCount <= 9'(vblankLine);
		cycles = 0;
		while (irq !== 1'b1 && cycles < irqTimeout) begin
			@(negedge CPUCL);
			cycles++;
		end
		if (irq !== 1'b1) begin
			errors++;
			aborted = 1'b1;
			$display("Timeout: irq never rose after vCount reached the blank line");
		end else begin
			checks++;
			// The first negedge falls before any clock edge has seen the new line.
			if (cycles - 1 != irqLatency) begin
				reportMismatch("irq latency", 16'(cycles - 1), 16'(irqLatency));
			end
			checks++;
			if (dmaBusy !== 1'b1) begin
				reportMismatch("dmaBusy", {15'd0, dmaBusy}, 16'd1);
			end
			@(posedge CPUCL);
			vCount <= 9'd0;
			cycles = 0;
			while (dmaBusy !== 1'b0 && cycles < dmaTimeout) begin
				@(negedge CPUCL);
				cycles++;
			end
			if (dmaBusy !== 1'b0) begin
				errors++;
				aborted = 1'b1;
				$display("Timeout: the sprite DMA never finished its copy");
			end
		end
	endtask

	task automatic ackIrq(addrT addr, byteT exp);
		checks++;
		if (irq !== 1'b1) begin
			errors++;
			$display("irq was not pending before the vector read at %0t ns", $time);
		end
		@(posedge CPUCL);
		cpuAddr <= addr;
		cpuRd <= 1'b1;
		cpuWr <= 1'b0;
		@(posedge CPUCL);
		@(negedge CPUCL);
		checks++;
		if (cpuRdData !== exp) begin
			reportMismatch("cpuRdData", {8'h00, cpuRdData}, {8'h00, exp});
		end
		checks++;
		if (irq !== 1'b0) begin
			reportMismatch("irq", {15'd0, irq}, 16'd0);
		end
		idleBus();
	endtask

	initial begin
		int fd;
		int n;
		int ch;
		logic [7:0] op;
		logic [15:0] addr;
		logic [15:0] value;
		errors = 0;
		checks = 0;
		aborted = 1'b0;
		rstN = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuWr = 1'b0;
		cpuRd = 1'b0;
		vCount = '0;
		bgAddr = '0;
		spriteAddr = '0;
		repeat (10) @(posedge CPUCL);
		rstN <= 1'b1;
		@(posedge CPUCL);

		fd = $fopen(goldenPath, "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the golden file %s", goldenPath);
		end else begin
			while (!aborted && $fscanf(fd, " %c", op) == 1) begin
				if (op == "#") begin
					ch = $fgetc(fd);
					while (ch != lineFeed && ch != -1) begin
						ch = $fgetc(fd);
					end
				end else begin
					n = $fscanf(fd, "%h %h", addr, value);
					if (n != 2) begin
						errors++;
						aborted = 1'b1;
						$display("Golden file line for opcode %c is missing its columns", op);
					end else begin
						case (op)
							"W": writeByte(addr, value[7:0]);
							"R": readCheck(addr, value[7:0]);
							"B": checkBg(addr[9:0], value);
							"S": checkSprite(addr[10:0], value[7:0]);
							"V": runVblank();
							"I": ackIrq(addr, value[7:0]);
							default: begin
								errors++;
								$display("Unknown opcode %c in the golden file", op);
							end
						endcase
					end
				end
			end
			$fclose(fd);
		end

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/memSubsys_golden.txt
# op addr value, hex. W write, R read and expect, B background word, S shadow byte,
# V vertical blank (columns unused), I vector read with expected ROM byte.
W C000 5A
R C000 5A
R C800 5A
W C7FF 3C
R CFFF 3C
W C123 81
R C923 81
# ROM model returns the low address byte XOR A5.
R 0012 B7
R 7FFF 5A
R E000 A5
R FFC3 66
R A000 00
R D000 00
W 8800 34
W 8801 12
B 0000 1234
R 8800 34
R 8801 12
W 8FFE EF
W 8FFF BE
B 03FF BEEF
# Clear the sprite bytes in the shadow copy first.
W 8000 00
W 8005 00
W 87FF 00
V 0000 00
I 0038 9D
W 8000 11
W 8005 22
W 87FF 33
R 8005 22
S 0000 00
S 0005 00
S 07FF 00
V 0000 00
R C000 5A
R 8000 11
I 0038 9D
S 0000 11
S 0005 22
S 07FF 33

// File: flist.f
hdl/boardPkg.sv
hdl/dualPortRam.sv
hdl/workRam.sv
hdl/spriteDma.sv
hdl/videoRam.sv
hdl/vblankIrq.sv
hdl/cpuReadMux.sv
hdl/memSubsys.sv
verification/memSubsys_props.sv
verification/memSubsysTb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module memSubsysTb -f flist.f -o memSubsysSim

./obj_dir/memSubsysSim 2>&1 | tee sim.log

grep -q '^>>> PASS$' sim.log
echo "Simulation passed."
